//--- sim.f
+incdir+hw
hw/rv32i_ex_pkg.sv
hw/ex_control.sv
hw/ex_operand_fwd.sv
hw/alu.sv
hw/branch_cmp.sv
hw/ex_stage_reg.sv
hw/ex_stage.sv
verification/ex_stage_properties.sv
verification/ex_stage_tb.sv

//--- verification/ex_stage_tb.sv
`timescale 1ns/1ps

module ex_stage_tb import rv32i_ex_pkg::*; ();

  typedef struct packed {
    rv32i_ctrl_t  ctrl;
    ex_in_t       din;
    rv32i_ctrl_t  wb_ctrl;
    rv32i_word    wb_data;
    logic         stall;
    logic         pred;
    redirect_t    exp_rd;
    logic         exp_upd;
    logic         exp_taken;
    rv32i_ctrl_t  exp_ctrl;
    ex_mem_data_t exp_data;
  } entry_t;

  logic         clk;
  logic         rst;
  rv32i_ctrl_t  id_ex_ctrl_i;
  ex_in_t       id_ex_i;
  rv32i_ctrl_t  mem_wb_ctrl_i;
  rv32i_word    mem_wb_data_i;
  logic         ma_stall_i;
  logic         pred_i;
  rv32i_ctrl_t  ex_mem_ctrl_o;
  ex_mem_data_t ex_mem_o;
  redirect_t    redirect_o;
  logic         pred_update_o;
  logic         pred_taken_o;
  entry_t       table_q[$];
  rv32i_ctrl_t  model_ctrl;  // Expected EX/MEM register contents
  ex_mem_data_t model_data;
  integer       seed;
  integer       cycles = 0;
  integer       limit = 1000;
  logic [4:0]   fwd_rd [0:6] = '{5'd5, 5'd5, 5'd8, 5'd0, 5'd9, 5'd11, 5'd12};

  ex_stage dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display(">>> FAIL");
      $fatal(1, "timeout, the table did not finish within %0d cycles", limit);
    end
  end

  task automatic check(input string name, input logic [159:0] got,
                       input logic [159:0] exp);
    if (got !== exp) begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  function automatic rv32i_ctrl_t mk_ctrl(rv32i_opcode_t op, alu_ops_t aop,
                                          branch_funct3_t cop, logic [4:0] rd,
                                          logic [2:0] srcs);
    rv32i_ctrl_t c;
    c.opcode = op;
    c.aluop = aop;
    c.cmpop = cop;
    c.pcmux_sel = (op == op_jalr) ? alu_mod2 : (op == op_jal || op == op_br) ? alu_out : pc_plus4;
    c.rd = rd;
    c.load_regfile = (op != op_br) && (op != op_store);
    {c.alu1_is_rs1, c.alu2_is_rs2, c.cmp2_is_rs2} = srcs;
    return c;
  endfunction

  // Callers patch immediates into this register form
  function automatic ex_in_t mk_in(logic [4:0] rs1, logic [4:0] rs2, logic [2:0] f3);
    ex_in_t d;
    d.pc = $random(seed) & 32'hffff_fffc;
    d.instr = {7'b0, rs2, rs1, f3, 12'h0};
    d.rs1 = $random(seed);
    d.rs2 = $random(seed);
    d.cmp_in = d.rs2;
    d.alu_in_1 = d.rs1;
    d.alu_in_2 = d.rs2;
    return d;
  endfunction

  function automatic rv32i_word fwd_val(rv32i_word base, logic [4:0] src, logic from_reg,
                                        rv32i_ctrl_t wbc, rv32i_word wbd);
    if (from_reg && model_ctrl.load_regfile && model_ctrl.rd == src && src != 0
        && model_ctrl.opcode != op_load)
      return model_data.alu_result;
    if (from_reg && wbc.load_regfile && wbc.rd == src && src != 0)
      return wbd;
    return base;
  endfunction

  task automatic add_entry(input rv32i_ctrl_t c, input ex_in_t d, input rv32i_ctrl_t wc,
                           input rv32i_word wd, input logic stall, input logic pr);
    entry_t     e;
    rv32i_word  a, b, ca, cb, sd, f, tgt;
    logic       taken;
    logic [3:0] be;
    a  = fwd_val(d.alu_in_1, d.instr[19:15], c.alu1_is_rs1, wc, wd);
    b  = fwd_val(d.alu_in_2, d.instr[24:20], c.alu2_is_rs2, wc, wd);
    ca = fwd_val(d.rs1, d.instr[19:15], 1'b1, wc, wd);
    cb = fwd_val(d.cmp_in, d.instr[24:20], c.cmp2_is_rs2, wc, wd);
    sd = fwd_val(d.rs2, d.instr[24:20], 1'b1, wc, wd);
    case (c.aluop)
      alu_add: f = a + b;
      alu_sub: f = a + ~b + 1;
      alu_sll: f = a << b[4:0];
      alu_srl: f = a >> b[4:0];
      alu_sra: f = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
      alu_xor: f = a ^ b;
      alu_or:  f = a | b;
      default: f = a & b;
    endcase
    tgt = (a + b) & 32'hffff_fffe;
    case (c.cmpop)
      beq:     taken = (ca == cb);
      bne:     taken = (ca != cb);
      blt:     taken = ($signed(ca) < $signed(cb));
      bge:     taken = ($signed(ca) >= $signed(cb));
      bltu:    taken = (ca < cb);
      default: taken = (ca >= cb);
    endcase
    e.exp_rd.br_miss = 1'b0;
    e.exp_rd.pcmux_sel = pc_plus4;
    e.exp_rd.target = tgt;
    if (c.opcode == op_jal || c.opcode == op_jalr || (c.opcode == op_br && taken != pr)) begin
      e.exp_rd.br_miss = 1'b1;
      e.exp_rd.pcmux_sel = c.pcmux_sel;
      if (c.opcode == op_br && pr)
        e.exp_rd.target = d.pc + 4;  // Fell through a predicted-taken branch
    end
    be = 4'b0000;
    if (c.opcode == op_load || c.opcode == op_store) begin
      case (d.instr[13:12])
        2'b10:   be = 4'b1111;
        2'b01:   be = 4'b0011;
        default: be = 4'b0001;
      endcase
    end
    be = be << f[1:0];
    if (!stall) begin
      model_ctrl = c;
      model_data = {d.pc, d.instr, f, sd, taken, be, f[1:0]};
    end
    e.ctrl = c;
    e.din = d;
    e.wb_ctrl = wc;
    e.wb_data = wd;
    e.stall = stall;
    e.pred = pr;
    e.exp_upd = (c.opcode == op_br);
    e.exp_taken = taken;
    e.exp_ctrl = model_ctrl;
    e.exp_data = model_data;
    table_q.push_back(e);
  endtask

  initial begin
    rv32i_ctrl_t c;
    rv32i_ctrl_t wc;
    ex_in_t      d;
    entry_t      e;
    seed = 32'h787f;
    model_ctrl = '0;
    model_data = '0;
    rst = 1'b1;
    id_ex_ctrl_i = '0;
    id_ex_i = '0;
    mem_wb_ctrl_i = '0;
    mem_wb_data_i = '0;
    ma_stall_i = 1'b0;
    pred_i = 1'b0;
    for (int i = 0; i < 16; i++) begin  // Eight ops in register then immediate form
      d = mk_in(5'(i + 1), 5'(i + 2), 3'b000);
      if (i >= 8)
        d.alu_in_2 = $random(seed);
      c = mk_ctrl(i >= 8 ? op_imm : op_reg, alu_ops_t'(i[2:0]), beq, 5'(i + 10),
                  {1'b1, i < 8, 1'b0});
      add_entry(c, d, '0, '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 24; i++) begin
      d = mk_in(5'd3, 5'd4, 3'b000);
      if (i[1])
        d.cmp_in = d.rs1;  // Equal operands
      d.alu_in_1 = d.pc;
      c = mk_ctrl(op_br, alu_add, branch_funct3_t'(3'((i / 4) + ((i >= 8) ? 2 : 0))),
                  5'd0, 3'b001);
      add_entry(c, d, '0, '0, 1'b0, i[0]);
    end
    for (int i = 0; i < 4; i++) begin
      d = mk_in(5'd7, 5'd0, 3'b000);
      if (!i[0])
        d.alu_in_1 = d.pc;  // jal is pc relative
      else
        d.alu_in_2[0] = ~d.alu_in_1[0];  // Odd sum so bit 0 must be cleared
      c = mk_ctrl(i[0] ? op_jalr : op_jal, alu_add, beq, 5'd1, {i[0], 2'b00});
      add_entry(c, d, '0, '0, 1'b0, i[1]);
    end
    // Producer then consumer with a gap for 1 and a load in EX/MEM for 6
    for (int s = 0; s < 7; s++) begin
      c = mk_ctrl(s == 6 ? op_load : op_reg, alu_add, beq, fwd_rd[s], 3'b110);
      add_entry(c, mk_in(5'd1, 5'd2, 3'b010), '0, '0, 1'b0, 1'b0);
      if (s == 1)
        add_entry(mk_ctrl(op_reg, alu_or, beq, 5'd7, 3'b110), mk_in(5'd1, 5'd2, 3'b000),
                  '0, '0, 1'b0, 1'b0);
      wc = mk_ctrl(op_reg, alu_add, beq, (s == 1 || s == 2) ? fwd_rd[s] : 5'd0, 3'b000);
      d = mk_in(fwd_rd[s], fwd_rd[s], 3'b010);
      c = mk_ctrl(s == 5 ? op_store : s == 4 ? op_imm : op_reg, alu_sub, beq, 5'd13,
                  (s == 4 || s == 5) ? 3'b100 : 3'b111);
      add_entry(c, d, wc, $random(seed), 1'b0, 1'b0);
    end
    for (int i = 0; i < 12; i++) begin
      d = mk_in(5'd1, 5'd2, 3'(i % 3));
      d.alu_in_1 = {d.alu_in_1[31:2], 2'b00};
      d.alu_in_2 = 32'(i / 3);  // Low address bits
      c = mk_ctrl(i[0] ? op_store : op_load, alu_add, beq, 5'd0, 3'b100);
      add_entry(c, d, '0, '0, 1'b0, 1'b0);
    end
    for (int i = 0; i < 4; i++) begin
      c = mk_ctrl(op_reg, alu_xor, beq, 5'(20 + i), 3'b110);
      add_entry(c, mk_in(5'd14, 5'd15, 3'b000), '0, '0, i == 1 || i == 2, 1'b0);
    end
    limit = 4 * table_q.size() + 50;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    check("ex_mem_ctrl_o", ex_mem_ctrl_o, '0);
    check("ex_mem_o", ex_mem_o, '0);
    foreach (table_q[k]) begin
      e = table_q[k];
      id_ex_ctrl_i = e.ctrl;
      id_ex_i = e.din;
      mem_wb_ctrl_i = e.wb_ctrl;
      mem_wb_data_i = e.wb_data;
      ma_stall_i = e.stall;
      pred_i = e.pred;
      #4;
      check("redirect_o", redirect_o, e.exp_rd);
      check("pred_update_o", pred_update_o, e.exp_upd);
      check("pred_taken_o", pred_taken_o, e.exp_taken);
      @(negedge clk);
      check("ex_mem_ctrl_o", ex_mem_ctrl_o, e.exp_ctrl);
      check("ex_mem_o", ex_mem_o, e.exp_data);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- verification/ex_stage_properties.sv
`timescale 1ns/1ps

module ex_stage_properties import rv32i_ex_pkg::*; (
  input logic         clk,
  input logic         rst,
  input logic         ma_stall_i,
  input rv32i_ctrl_t  ex_mem_ctrl_o,
  input ex_mem_data_t ex_mem_o,
  input redirect_t    redirect_o
);

  // No write-back request leaves a reset cycle
  assert property (@(posedge clk) rst |=> !ex_mem_ctrl_o.load_regfile)
    else $error("load_regfile set the cycle after reset");

  assert property (@(posedge clk) disable iff (rst)
                   ma_stall_i |=> $stable(ex_mem_ctrl_o) && $stable(ex_mem_o))
    else $error("EX/MEM register changed during a memory stall");

  assert property (@(posedge clk) !redirect_o.br_miss |-> redirect_o.pcmux_sel == pc_plus4)
    else $error("pcmux_sel off pc_plus4 without a redirect");

endmodule

bind ex_stage ex_stage_properties props0 (.*);

//--- hw/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import rv32i_ex_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  rv32i_ctrl_t  id_ex_ctrl_i,
  input  ex_in_t       id_ex_i,
  input  rv32i_ctrl_t  mem_wb_ctrl_i,
  input  rv32i_word    mem_wb_data_i,
  input  logic         ma_stall_i,
  input  logic         pred_i,
  output rv32i_ctrl_t  ex_mem_ctrl_o,
  output ex_mem_data_t ex_mem_o,
  output redirect_t    redirect_o,
  output logic         pred_update_o,
  output logic         pred_taken_o
);

  fwd_sel_t     fwd_alu1, fwd_alu2, fwd_cmp1, fwd_cmp2, fwd_rs2;
  rv32i_word    alu_a, alu_b, cmp_a, cmp_b, store_data;
  rv32i_word    alu_f;
  rv32i_word    alu_target;
  logic         br_en;
  logic         is_mem_op;
  logic [3:0]   mem_be;
  ex_mem_data_t ex_mem_d;

  ex_control u_control (
    .id_ex_ctrl_i  (id_ex_ctrl_i),
    .instr_i       (id_ex_i.instr),
    .ex_mem_ctrl_i (ex_mem_ctrl_o),  // Registered copy is the EX/MEM source
    .mem_wb_ctrl_i (mem_wb_ctrl_i),
    .pc_i          (id_ex_i.pc),
    .br_en_i       (br_en),
    .alu_target_i  (alu_target),
    .pred_i        (pred_i),
    .fwd_alu1_o    (fwd_alu1),
    .fwd_alu2_o    (fwd_alu2),
    .fwd_cmp1_o    (fwd_cmp1),
    .fwd_cmp2_o    (fwd_cmp2),
    .fwd_rs2_o     (fwd_rs2),
    .redirect_o    (redirect_o),
    .pred_update_o (pred_update_o),
    .pred_taken_o  (pred_taken_o)
  );

  ex_operand_fwd u_fwd (
    .fwd_alu1_i      (fwd_alu1),
    .fwd_alu2_i      (fwd_alu2),
    .fwd_cmp1_i      (fwd_cmp1),
    .fwd_cmp2_i      (fwd_cmp2),
    .fwd_rs2_i       (fwd_rs2),
    .stage_i         (id_ex_i),
    .mem_wb_data_i   (mem_wb_data_i),
    .ex_mem_result_i (ex_mem_o.alu_result),
    .alu_a_o         (alu_a),
    .alu_b_o         (alu_b),
    .cmp_a_o         (cmp_a),
    .cmp_b_o         (cmp_b),
    .store_data_o    (store_data)
  );

  alu u_alu (
    .aluop_i  (id_ex_ctrl_i.aluop),
    .a_i      (alu_a),
    .b_i      (alu_b),
    .f_o      (alu_f),
    .target_o (alu_target)
  );

  branch_cmp u_cmp (
    .cmpop_i (id_ex_ctrl_i.cmpop),
    .a_i     (cmp_a),
    .b_i     (cmp_b),
    .br_en_o (br_en)
  );

  assign is_mem_op = (id_ex_ctrl_i.opcode == op_load) || (id_ex_ctrl_i.opcode == op_store);

  // Byte lanes from access size, shifted to the address offset
  always_comb begin
    mem_be = 4'b0000;
    if (is_mem_op) begin
      case (load_funct3_t'(id_ex_i.instr[14:12]))
        lw:       mem_be = 4'b1111 << alu_f[1:0];
        lh, lhu:  mem_be = 4'b0011 << alu_f[1:0];
        lb, lbu:  mem_be = 4'b0001 << alu_f[1:0];
        default:  mem_be = 4'b0000;
      endcase
    end
  end

  always_comb begin
    ex_mem_d.pc          = id_ex_i.pc;
    ex_mem_d.instr       = id_ex_i.instr;
    ex_mem_d.alu_result  = alu_f;
    ex_mem_d.rs2         = store_data;
    ex_mem_d.br_en       = br_en;
    ex_mem_d.mem_be      = mem_be;
    ex_mem_d.addr_offset = alu_f[1:0];
  end

  ex_stage_reg #(.T(rv32i_ctrl_t)) u_ctrl_reg (
    .clk    (clk),
    .rst    (rst),
    .hold_i (ma_stall_i),
    .d_i    (id_ex_ctrl_i),
    .q_o    (ex_mem_ctrl_o)
  );

  ex_stage_reg #(.T(ex_mem_data_t)) u_data_reg (
    .clk    (clk),
    .rst    (rst),
    .hold_i (ma_stall_i),
    .d_i    (ex_mem_d),
    .q_o    (ex_mem_o)
  );

endmodule

//--- hw/ex_stage_reg.sv
`timescale 1ns/1ps

module ex_stage_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic hold_i,
  input  T     d_i,
  output T     q_o
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q_o <= '0;
    end else if (!hold_i) begin
      q_o <= d_i;  // Memory stage ready
    end
  end

endmodule

//--- hw/branch_cmp.sv
`timescale 1ns/1ps

module branch_cmp import rv32i_ex_pkg::*; (
  input  branch_funct3_t cmpop_i,
  input  rv32i_word      a_i,
  input  rv32i_word      b_i,
  output logic           br_en_o
);

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    case (cmpop_i)
      beq:     br_en_o = eq;
      bne:     br_en_o = !eq;
      blt:     br_en_o = lt_s;
      bge:     br_en_o = !lt_s;
      bltu:    br_en_o = lt_u;
      bgeu:    br_en_o = !lt_u;
      default: br_en_o = 1'b0;  // Reserved funct3 never taken
    endcase
  end

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps

module alu import rv32i_ex_pkg::*; (
  input  alu_ops_t  aluop_i,
  input  rv32i_word a_i,
  input  rv32i_word b_i,
  output rv32i_word f_o,
  output rv32i_word target_o
);

  rv32i_word  sum;
  logic [4:0] shamt;

  assign sum   = a_i + b_i;
  assign shamt = b_i[4:0];  // RV32I uses only the low five bits

  always_comb begin
    case (aluop_i)
      alu_add: f_o = sum;
      alu_sll: f_o = a_i << shamt;
      alu_sra: f_o = rv32i_word'($signed(a_i) >>> shamt);
      alu_sub: f_o = a_i - b_i;
      alu_xor: f_o = a_i ^ b_i;
      alu_srl: f_o = a_i >> shamt;
      alu_or:  f_o = a_i | b_i;
      alu_and: f_o = a_i & b_i;
      default: f_o = sum;
    endcase
  end

  // Jump target, bit 0 forced low for jalr
  assign target_o = sum & ~rv32i_word'(1);

endmodule

//--- hw/ex_operand_fwd.sv
`timescale 1ns/1ps

module ex_operand_fwd import rv32i_ex_pkg::*; (
  input  fwd_sel_t  fwd_alu1_i,
  input  fwd_sel_t  fwd_alu2_i,
  input  fwd_sel_t  fwd_cmp1_i,
  input  fwd_sel_t  fwd_cmp2_i,
  input  fwd_sel_t  fwd_rs2_i,
  input  ex_in_t    stage_i,
  input  rv32i_word mem_wb_data_i,
  input  rv32i_word ex_mem_result_i,
  output rv32i_word alu_a_o,
  output rv32i_word alu_b_o,
  output rv32i_word cmp_a_o,
  output rv32i_word cmp_b_o,
  output rv32i_word store_data_o
);

  // One three-way mux shared by all five operands
  function automatic rv32i_word fwd_mux(input fwd_sel_t sel, input rv32i_word base,
                                        input rv32i_word mem_val, input rv32i_word wb_val);
    case (sel)
      fwd_mem: return mem_val;
      fwd_wb:  return wb_val;
      default: return base;
    endcase
  endfunction

  assign alu_a_o      = fwd_mux(fwd_alu1_i, stage_i.alu_in_1, ex_mem_result_i, mem_wb_data_i);
  assign alu_b_o      = fwd_mux(fwd_alu2_i, stage_i.alu_in_2, ex_mem_result_i, mem_wb_data_i);
  assign cmp_a_o      = fwd_mux(fwd_cmp1_i, stage_i.rs1, ex_mem_result_i, mem_wb_data_i);
  // Immediate or rs2
  assign cmp_b_o      = fwd_mux(fwd_cmp2_i, stage_i.cmp_in, ex_mem_result_i, mem_wb_data_i);
  assign store_data_o = fwd_mux(fwd_rs2_i, stage_i.rs2, ex_mem_result_i, mem_wb_data_i);

endmodule

//--- hw/ex_control.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_control import rv32i_ex_pkg::*; (
  input  rv32i_ctrl_t id_ex_ctrl_i,
  input  rv32i_word   instr_i,
  input  rv32i_ctrl_t ex_mem_ctrl_i,
  input  rv32i_ctrl_t mem_wb_ctrl_i,
  input  rv32i_word   pc_i,
  input  logic        br_en_i,
  input  rv32i_word   alu_target_i,
  input  logic        pred_i,
  output fwd_sel_t    fwd_alu1_o,
  output fwd_sel_t    fwd_alu2_o,
  output fwd_sel_t    fwd_cmp1_o,
  output fwd_sel_t    fwd_cmp2_o,
  output fwd_sel_t    fwd_rs2_o,
  output redirect_t   redirect_o,
  output logic        pred_update_o,
  output logic        pred_taken_o
);

  logic [`EX_REGW-1:0] rs1_idx;
  logic [`EX_REGW-1:0] rs2_idx;
  logic                is_jump;
  logic                is_branch;

  assign rs1_idx   = instr_i[19:15];
  assign rs2_idx   = instr_i[24:20];
  assign is_jump   = (id_ex_ctrl_i.opcode == op_jal) || (id_ex_ctrl_i.opcode == op_jalr);
  assign is_branch = (id_ex_ctrl_i.opcode == op_br);

  // EX/MEM wins over MEM/WB and a load in EX/MEM has no data yet
  function automatic fwd_sel_t pick_src(input logic [`EX_REGW-1:0] src,
                                        input logic from_reg,
                                        input rv32i_ctrl_t mem_c,
                                        input rv32i_ctrl_t wb_c);
    logic mem_hit;
    logic wb_hit;
    mem_hit = from_reg && mem_c.load_regfile
              && (mem_c.rd != '0) && (mem_c.rd == src)
              && (mem_c.opcode != op_load);
    wb_hit  = from_reg && wb_c.load_regfile
              && (wb_c.rd != '0) && (wb_c.rd == src);
    if (mem_hit) begin
      return fwd_mem;
    end else if (wb_hit) begin
      return fwd_wb;
    end
    return fwd_none;
  endfunction

  assign fwd_alu1_o = pick_src(rs1_idx, id_ex_ctrl_i.alu1_is_rs1,
                               ex_mem_ctrl_i, mem_wb_ctrl_i);
  assign fwd_alu2_o = pick_src(rs2_idx, id_ex_ctrl_i.alu2_is_rs2,
                               ex_mem_ctrl_i, mem_wb_ctrl_i);
  assign fwd_cmp1_o = pick_src(rs1_idx, 1'b1, ex_mem_ctrl_i, mem_wb_ctrl_i);
  assign fwd_cmp2_o = pick_src(rs2_idx, id_ex_ctrl_i.cmp2_is_rs2,
                               ex_mem_ctrl_i, mem_wb_ctrl_i);
  // Store data is always rs2
  assign fwd_rs2_o  = pick_src(rs2_idx, 1'b1, ex_mem_ctrl_i, mem_wb_ctrl_i);

  always_comb begin
    redirect_o.br_miss   = 1'b0;
    redirect_o.pcmux_sel = pc_plus4;
    redirect_o.target    = alu_target_i;
    if (is_jump) begin
      redirect_o.br_miss   = 1'b1;  // No jump prediction
      redirect_o.pcmux_sel = id_ex_ctrl_i.pcmux_sel;
    end else if (is_branch && (br_en_i != pred_i)) begin
      redirect_o.br_miss   = 1'b1;
      redirect_o.pcmux_sel = id_ex_ctrl_i.pcmux_sel;
      // Predicted taken but fell through so fetch resumes after the branch
      if (pred_i) begin
        redirect_o.target = pc_i + rv32i_word'(4);
      end
    end
  end

  // Predictor trains on every resolved branch
  assign pred_update_o = is_branch;
  assign pred_taken_o  = br_en_i;

endmodule

//--- hw/rv32i_ex_pkg.sv
`include "ex_config.svh"

package rv32i_ex_pkg;

  typedef logic [`EX_XLEN-1:0] rv32i_word;

  typedef enum logic [6:0] {
    op_lui   = 7'b0110111,
    op_auipc = 7'b0010111,
    op_jal   = 7'b1101111,
    op_jalr  = 7'b1100111,
    op_br    = 7'b1100011,
    op_load  = 7'b0000011,
    op_store = 7'b0100011,
    op_imm   = 7'b0010011,
    op_reg   = 7'b0110011
  } rv32i_opcode_t;

  // Encoding follows the decode stage, not funct3
  typedef enum logic [`EX_ALUOP_W-1:0] {
    alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
  } alu_ops_t;

  typedef enum logic [`EX_CMPOP_W-1:0] {
    beq  = 3'b000,
    bne  = 3'b001,
    blt  = 3'b100,
    bge  = 3'b101,
    bltu = 3'b110,
    bgeu = 3'b111
  } branch_funct3_t;

  // Store funct3 (sb/sh/sw) shares the lb/lh/lw codes
  typedef enum logic [`EX_CMPOP_W-1:0] {
    lb  = 3'b000,
    lh  = 3'b001,
    lw  = 3'b010,
    lbu = 3'b100,
    lhu = 3'b101
  } load_funct3_t;

  typedef enum logic [1:0] {pc_plus4, alu_out, alu_mod2} pcmux_sel_t;

  typedef enum logic [1:0] {fwd_none, fwd_wb, fwd_mem} fwd_sel_t;

  typedef struct packed {
    rv32i_opcode_t      opcode;
    alu_ops_t           aluop;
    branch_funct3_t     cmpop;
    pcmux_sel_t         pcmux_sel;
    logic [`EX_REGW-1:0] rd;
    logic               load_regfile;
    logic               alu1_is_rs1;  // ALU operand 1 read from a register
    logic               alu2_is_rs2;  // ALU operand 2 read from a register
    logic               cmp2_is_rs2;  // Comparator operand 2 is rs2, not an immediate
  } rv32i_ctrl_t;

  typedef struct packed {
    rv32i_word pc;
    rv32i_word instr;
    rv32i_word alu_in_1;
    rv32i_word alu_in_2;
    rv32i_word rs1;
    rv32i_word rs2;
    rv32i_word cmp_in;
  } ex_in_t;

  typedef struct packed {
    rv32i_word  pc;
    rv32i_word  instr;
    rv32i_word  alu_result;
    rv32i_word  rs2;          // Store data after forwarding
    logic       br_en;
    logic [3:0] mem_be;
    logic [1:0] addr_offset;
  } ex_mem_data_t;

  typedef struct packed {
    logic       br_miss;
    pcmux_sel_t pcmux_sel;
    rv32i_word  target;
  } redirect_t;

endpackage

//--- hw/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// Datapath word width
`define EX_XLEN 32

// Register file index width
`define EX_REGW 5

// ALU operation field width
`define EX_ALUOP_W 3

// Branch compare / funct3 field width
`define EX_CMPOP_W 3

`endif
